//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////
    // datapath widths
    //////////////////////////////

    localparam int xlen        = 32;
    localparam int phy_bits    = 6;
    localparam int rob_bits    = 5;
    localparam int op_bits     = 3;

    //////////////////////////////
    // station and bus depths
    //////////////////////////////

    localparam int rs_depth    = 8;
    localparam int rs_idx_bits = 3;
    localparam int cdb_width   = 2;
    // index of a cdb lane
    localparam int lane_bits   = $clog2(cdb_width);

    //////////////////////////////
    // memory opcodes
    //////////////////////////////

    // bit 2 alone does not separate loads from stores
    localparam logic [op_bits-1:0] op_lb  = 3'd0;
    localparam logic [op_bits-1:0] op_lh  = 3'd1;
    localparam logic [op_bits-1:0] op_lw  = 3'd2;
    localparam logic [op_bits-1:0] op_sw  = 3'd3;
    localparam logic [op_bits-1:0] op_lbu = 3'd4;
    localparam logic [op_bits-1:0] op_lhu = 3'd5;
    localparam logic [op_bits-1:0] op_sb  = 3'd6;
    localparam logic [op_bits-1:0] op_sh  = 3'd7;

    // access size, derived from the opcode
    localparam logic [1:0] size_b = 2'd0;
    localparam logic [1:0] size_h = 2'd1;
    localparam logic [1:0] size_w = 2'd2;

endpackage

`default_nettype wire

//--- source/phys_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module phys_regfile import mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,

    // writeback from the cdb lanes
    input  wire                 cdb_valid [cdb_width],
    input  wire  [phy_bits-1:0] cdb_phy   [cdb_width],
    input  wire  [xlen-1:0]     cdb_value [cdb_width],

    // issue read ports
    input  wire  [phy_bits-1:0] rd1_phy,
    input  wire  [phy_bits-1:0] rd2_phy,
    output logic [xlen-1:0]     rd1_value,
    output logic [xlen-1:0]     rd2_value
);

    localparam int phy_count = 1 << phy_bits;

    logic [xlen-1:0] regs [phy_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < phy_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // higher lane lands last on a shared index
            for (int k = 0; k < cdb_width; k++) begin
                if (cdb_valid[k]) begin
                    regs[cdb_phy[k]] <= cdb_value[k];
                end
            end
        end
    end

    // live cdb values reach the agu through the station forward path
    // p0 always reads as zero
    assign rd1_value = (rd1_phy == '0) ? '0 : regs[rd1_phy];
    assign rd2_value = (rd2_phy == '0) ? '0 : regs[rd2_phy];

endmodule

`default_nettype wire

//--- source/mem_rs.sv
`timescale 1ns/100ps
`default_nettype none

module mem_rs import mem_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    // dispatch
    input  wire                  disp_valid,
    output logic                 disp_ready,
    input  wire  [rob_bits-1:0]  disp_rob_id,
    input  wire  [op_bits-1:0]   disp_op,
    input  wire  [xlen-1:0]      disp_imm,
    input  wire  [phy_bits-1:0]  disp_rs1_phy,
    input  wire                  disp_rs1_rdy,
    input  wire  [phy_bits-1:0]  disp_rs2_phy,
    input  wire                  disp_rs2_rdy,

    // cdb snoop
    input  wire                  cdb_valid [cdb_width],
    input  wire  [phy_bits-1:0]  cdb_phy   [cdb_width],

    // issue
    output logic                 iss_valid,
    output logic [rob_bits-1:0]  iss_rob_id,
    output logic [op_bits-1:0]   iss_op,
    output logic [xlen-1:0]      iss_imm,
    output logic [phy_bits-1:0]  iss_rs1_phy,
    output logic [phy_bits-1:0]  iss_rs2_phy,
    output logic                 rs1_fwd,
    output logic [lane_bits-1:0] rs1_fwd_lane,
    output logic                 rs2_fwd,
    output logic [lane_bits-1:0] rs2_fwd_lane
);

    //////////////////////////////
    // entry storage
    //////////////////////////////

    logic [rs_depth-1:0] ent_valid;
    logic [rob_bits-1:0] ent_rob_id  [rs_depth];
    logic [op_bits-1:0]  ent_op      [rs_depth];
    logic [xlen-1:0]     ent_imm     [rs_depth];
    logic [phy_bits-1:0] ent_rs1_phy [rs_depth];
    logic [phy_bits-1:0] ent_rs2_phy [rs_depth];
    logic [rs_depth-1:0] ent_rs1_rdy;
    logic [rs_depth-1:0] ent_rs2_rdy;

    // live cdb matches per entry
    logic [rs_depth-1:0]  src1_hit;
    logic [rs_depth-1:0]  src2_hit;
    logic [lane_bits-1:0] src1_lane [rs_depth];
    logic [lane_bits-1:0] src2_lane [rs_depth];
    logic [rs_depth-1:0]  ent_go;

    logic                   disp1_hit;
    logic                   disp2_hit;
    logic                   push_en;
    logic [rs_idx_bits-1:0] push_idx;
    logic [rs_idx_bits-1:0] issue_idx;

    always_comb begin
        disp1_hit = 1'b0;
        disp2_hit = 1'b0;
        for (int k = 0; k < cdb_width; k++) begin
            disp1_hit |= cdb_valid[k] && (cdb_phy[k] == disp_rs1_phy);
            disp2_hit |= cdb_valid[k] && (cdb_phy[k] == disp_rs2_phy);
        end
        for (int i = 0; i < rs_depth; i++) begin
            src1_hit[i]  = 1'b0;
            src2_hit[i]  = 1'b0;
            src1_lane[i] = '0;
            src2_lane[i] = '0;
            for (int k = 0; k < cdb_width; k++) begin
                if (cdb_valid[k] && (cdb_phy[k] == ent_rs1_phy[i])) begin
                    src1_hit[i]  = 1'b1;
                    src1_lane[i] = lane_bits'(k);
                end
                if (cdb_valid[k] && (cdb_phy[k] == ent_rs2_phy[i])) begin
                    src2_hit[i]  = 1'b1;
                    src2_lane[i] = lane_bits'(k);
                end
            end
        end
        ent_go = ent_valid & (ent_rs1_rdy | src1_hit) & (ent_rs2_rdy | src2_hit);
    end

    // lowest free slot and lowest ready entry
    always_comb begin
        push_idx  = '0;
        issue_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                push_idx = rs_idx_bits'(i);
            end
            if (ent_go[i]) begin
                issue_idx = rs_idx_bits'(i);
            end
        end
    end

    assign disp_ready = ~&ent_valid;
    assign push_en    = disp_valid && disp_ready;
    assign iss_valid  = |ent_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
        end else begin
            // wakeup on a live broadcast during the push edge too
            if (push_en) begin
                ent_valid[push_idx]   <= 1'b1;
                ent_rob_id[push_idx]  <= disp_rob_id;
                ent_op[push_idx]      <= disp_op;
                ent_imm[push_idx]     <= disp_imm;
                ent_rs1_phy[push_idx] <= disp_rs1_phy;
                ent_rs2_phy[push_idx] <= disp_rs2_phy;
                ent_rs1_rdy[push_idx] <= disp_rs1_rdy | disp1_hit;
                ent_rs2_rdy[push_idx] <= disp_rs2_rdy | disp2_hit;
            end
            for (int i = 0; i < rs_depth; i++) begin
                if (ent_valid[i] && src1_hit[i]) begin
                    ent_rs1_rdy[i] <= 1'b1;
                end
                if (ent_valid[i] && src2_hit[i]) begin
                    ent_rs2_rdy[i] <= 1'b1;
                end
            end
            if (iss_valid) begin
                ent_valid[issue_idx] <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // issue outputs
    //////////////////////////////

    assign iss_rob_id   = ent_rob_id[issue_idx];
    assign iss_op       = ent_op[issue_idx];
    assign iss_imm      = ent_imm[issue_idx];
    assign iss_rs1_phy  = ent_rs1_phy[issue_idx];
    assign iss_rs2_phy  = ent_rs2_phy[issue_idx];

    // forward only when the cdb alone made the source ready
    assign rs1_fwd      = src1_hit[issue_idx] && !ent_rs1_rdy[issue_idx];
    assign rs2_fwd      = src2_hit[issue_idx] && !ent_rs2_rdy[issue_idx];
    assign rs1_fwd_lane = src1_lane[issue_idx];
    assign rs2_fwd_lane = src2_lane[issue_idx];

endmodule

`default_nettype wire

//--- source/mem_agu.sv
`timescale 1ns/100ps
`default_nettype none

module mem_agu import mem_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    input  wire                  iss_valid,
    input  wire  [rob_bits-1:0]  iss_rob_id,
    input  wire  [op_bits-1:0]   iss_op,
    input  wire  [xlen-1:0]      iss_imm,
    input  wire  [xlen-1:0]      rd1_value,
    input  wire  [xlen-1:0]      rd2_value,
    input  wire                  rs1_fwd,
    input  wire  [lane_bits-1:0] rs1_fwd_lane,
    input  wire                  rs2_fwd,
    input  wire  [lane_bits-1:0] rs2_fwd_lane,
    input  wire  [xlen-1:0]      cdb_value [cdb_width],

    output logic                 lsq_valid,
    output logic [rob_bits-1:0]  lsq_rob_id,
    output logic                 lsq_store,
    output logic [xlen-1:0]      lsq_addr,
    output logic [3:0]           lsq_mask,
    output logic [xlen-1:0]      lsq_data,
    output logic                 lsq_misaligned
);

    //////////////////////////////
    // stage 1: operands and sum
    //////////////////////////////

    logic [xlen-1:0]     base;
    logic [xlen-1:0]     sval;
    logic                s1_valid;
    logic [rob_bits-1:0] s1_rob_id;
    logic [op_bits-1:0]  s1_op;
    logic [xlen-1:0]     s1_addr;
    logic [xlen-1:0]     s1_sval;

    assign base = rs1_fwd ? cdb_value[rs1_fwd_lane] : rd1_value;
    assign sval = rs2_fwd ? cdb_value[rs2_fwd_lane] : rd2_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= iss_valid;
        end
        s1_rob_id <= iss_rob_id;
        s1_op     <= iss_op;
        s1_addr   <= base + iss_imm;
        s1_sval   <= sval;
    end

    //////////////////////////////
    // stage 2: decode and output
    //////////////////////////////

    logic            is_store;
    logic [1:0]      size;
    logic [3:0]      mask_base;
    logic [xlen-1:0] data_rep;
    logic            misaligned;

    assign is_store = (s1_op == op_sb) || (s1_op == op_sh) || (s1_op == op_sw);

    always_comb begin
        case (s1_op)
            op_lb, op_lbu, op_sb: size = size_b;
            op_lh, op_lhu, op_sh: size = size_h;
            default:              size = size_w;
        endcase
        case (size)
            size_b:  mask_base = 4'b0001;
            size_h:  mask_base = 4'b0011;
            default: mask_base = 4'b1111;
        endcase
        case (size)
            size_b:  data_rep = {4{s1_sval[7:0]}};
            size_h:  data_rep = {2{s1_sval[15:0]}};
            default: data_rep = s1_sval;
        endcase
        misaligned = ((size == size_h) && s1_addr[0]) ||
                     ((size == size_w) && (s1_addr[1:0] != 2'b00));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lsq_valid <= 1'b0;
        end else begin
            lsq_valid <= s1_valid;
        end
        lsq_rob_id     <= s1_rob_id;
        lsq_store      <= is_store;
        lsq_addr       <= s1_addr;
        lsq_mask       <= mask_base << s1_addr[1:0];
        // loads carry no store data
        lsq_data       <= is_store ? data_rep : '0;
        lsq_misaligned <= misaligned;
    end

endmodule

`default_nettype wire

//--- source/mem_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue_top import mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,

    // dispatch
    input  wire                 disp_valid,
    output logic                disp_ready,
    input  wire  [rob_bits-1:0] disp_rob_id,
    input  wire  [op_bits-1:0]  disp_op,
    input  wire  [xlen-1:0]     disp_imm,
    input  wire  [phy_bits-1:0] disp_rs1_phy,
    input  wire                 disp_rs1_rdy,
    input  wire  [phy_bits-1:0] disp_rs2_phy,
    input  wire                 disp_rs2_rdy,

    // cdb
    input  wire                 cdb_valid [cdb_width],
    input  wire  [phy_bits-1:0] cdb_phy   [cdb_width],
    input  wire  [xlen-1:0]     cdb_value [cdb_width],

    // toward the lsq
    output logic                lsq_valid,
    output logic [rob_bits-1:0] lsq_rob_id,
    output logic                lsq_store,
    output logic [xlen-1:0]     lsq_addr,
    output logic [3:0]          lsq_mask,
    output logic [xlen-1:0]     lsq_data,
    output logic                lsq_misaligned
);

    logic                 iss_valid;
    logic [rob_bits-1:0]  iss_rob_id;
    logic [op_bits-1:0]   iss_op;
    logic [xlen-1:0]      iss_imm;
    logic [phy_bits-1:0]  iss_rs1_phy;
    logic [phy_bits-1:0]  iss_rs2_phy;
    logic                 rs1_fwd;
    logic [lane_bits-1:0] rs1_fwd_lane;
    logic                 rs2_fwd;
    logic [lane_bits-1:0] rs2_fwd_lane;
    logic [xlen-1:0]      rd1_value;
    logic [xlen-1:0]      rd2_value;

    mem_rs u_rs (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_ready   (disp_ready),
        .disp_rob_id  (disp_rob_id),
        .disp_op      (disp_op),
        .disp_imm     (disp_imm),
        .disp_rs1_phy (disp_rs1_phy),
        .disp_rs1_rdy (disp_rs1_rdy),
        .disp_rs2_phy (disp_rs2_phy),
        .disp_rs2_rdy (disp_rs2_rdy),
        .cdb_valid    (cdb_valid),
        .cdb_phy      (cdb_phy),
        .iss_valid    (iss_valid),
        .iss_rob_id   (iss_rob_id),
        .iss_op       (iss_op),
        .iss_imm      (iss_imm),
        .iss_rs1_phy  (iss_rs1_phy),
        .iss_rs2_phy  (iss_rs2_phy),
        .rs1_fwd      (rs1_fwd),
        .rs1_fwd_lane (rs1_fwd_lane),
        .rs2_fwd      (rs2_fwd),
        .rs2_fwd_lane (rs2_fwd_lane)
    );

    // register file read ports follow the issue select
    phys_regfile u_prf (
        .clk       (clk),
        .rst       (rst),
        .cdb_valid (cdb_valid),
        .cdb_phy   (cdb_phy),
        .cdb_value (cdb_value),
        .rd1_phy   (iss_rs1_phy),
        .rd2_phy   (iss_rs2_phy),
        .rd1_value (rd1_value),
        .rd2_value (rd2_value)
    );

    mem_agu u_agu (
        .clk            (clk),
        .rst            (rst),
        .iss_valid      (iss_valid),
        .iss_rob_id     (iss_rob_id),
        .iss_op         (iss_op),
        .iss_imm        (iss_imm),
        .rd1_value      (rd1_value),
        .rd2_value      (rd2_value),
        .rs1_fwd        (rs1_fwd),
        .rs1_fwd_lane   (rs1_fwd_lane),
        .rs2_fwd        (rs2_fwd),
        .rs2_fwd_lane   (rs2_fwd_lane),
        .cdb_value      (cdb_value),
        .lsq_valid      (lsq_valid),
        .lsq_rob_id     (lsq_rob_id),
        .lsq_store      (lsq_store),
        .lsq_addr       (lsq_addr),
        .lsq_mask       (lsq_mask),
        .lsq_data       (lsq_data),
        .lsq_misaligned (lsq_misaligned)
    );

endmodule

`default_nettype wire

//--- test/mem_issue_props.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue_props import mem_pkg::*; (
    input  wire clk,
    input  wire rst,
    input  wire disp_valid,
    input  wire disp_ready,
    input  wire iss_valid,
    input  wire lsq_valid
);

    logic                 push;
    logic [rs_idx_bits:0] held;

    assign push = disp_valid && disp_ready;

    // station occupancy from the dispatch and issue handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (push && !iss_valid) begin
            held <= held + 1'b1;
        end else if (!push && iss_valid) begin
            held <= held - 1'b1;
        end
    end

    // station only refuses dispatch when every slot is held
    ready_low_means_full: assert property (
        @(posedge clk) disable iff (rst) !disp_ready |-> (held == rs_depth)
    ) else $error("disp_ready low while a station entry is free");

    // an issued entry was pushed on an earlier edge
    issue_from_valid_entry: assert property (
        @(posedge clk) disable iff (rst) iss_valid |-> (held != 0)
    ) else $error("issue while no station entry is held");

    // two registers between issue and the lsq
    lsq_after_issue: assert property (
        @(posedge clk) disable iff (rst) iss_valid |-> ##2 lsq_valid
    ) else $error("lsq_valid missing two cycles after issue");

    lsq_needs_issue: assert property (
        @(posedge clk) disable iff (rst) lsq_valid |-> $past(iss_valid, 2)
    ) else $error("lsq_valid without an issue two cycles earlier");

endmodule

`default_nettype wire

//--- test/mem_issue_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue_checker import mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 disp_valid,
    input  wire                 disp_ready,
    input  wire  [rob_bits-1:0] disp_rob_id,
    input  wire  [op_bits-1:0]  disp_op,
    input  wire  [xlen-1:0]     disp_imm,
    input  wire  [phy_bits-1:0] disp_rs1_phy,
    input  wire                 disp_rs1_rdy,
    input  wire  [phy_bits-1:0] disp_rs2_phy,
    input  wire                 disp_rs2_rdy,
    input  wire                 cdb_valid [cdb_width],
    input  wire  [phy_bits-1:0] cdb_phy   [cdb_width],
    input  wire  [xlen-1:0]     cdb_value [cdb_width],
    input  wire                 lsq_valid,
    input  wire  [rob_bits-1:0] lsq_rob_id,
    input  wire                 lsq_store,
    input  wire  [xlen-1:0]     lsq_addr,
    input  wire  [3:0]          lsq_mask,
    input  wire  [xlen-1:0]     lsq_data,
    input  wire                 lsq_misaligned
);

    int err_count = 0;
    int checked = 0;
    int outstanding = 0;

    // register values as seen on the cdb
    logic [xlen-1:0]     mirror [64];

    // micro-ops in flight, keyed by rob id
    logic [31:0]         pend;
    logic [op_bits-1:0]  op_of   [32];
    logic [xlen-1:0]     imm_of  [32];
    logic [phy_bits-1:0] src1_of [32];
    logic [phy_bits-1:0] src2_of [32];
    logic [31:0]         known1;
    logic [31:0]         known2;
    logic [xlen-1:0]     val1_of [32];
    logic [xlen-1:0]     val2_of [32];

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic capture_wakeups();
        for (int r = 0; r < 32; r++) begin
            for (int k = 0; k < cdb_width; k++) begin
                if (pend[r] && cdb_valid[k] && !known1[r] && cdb_phy[k] == src1_of[r]) begin
                    val1_of[r] = cdb_value[k];
                    known1[r]  = 1'b1;
                end
                if (pend[r] && cdb_valid[k] && !known2[r] && cdb_phy[k] == src2_of[r]) begin
                    val2_of[r] = cdb_value[k];
                    known2[r]  = 1'b1;
                end
            end
        end
    endtask

    task automatic record_dispatch();
        logic [rob_bits-1:0] id;
        id = disp_rob_id;
        if (pend[id]) begin
            $display("Fail time=%0t rob id %0d dispatched while still in flight", $time, id);
            err_count++;
        end
        pend[id]    = 1'b1;
        op_of[id]   = disp_op;
        imm_of[id]  = disp_imm;
        src1_of[id] = disp_rs1_phy;
        src2_of[id] = disp_rs2_phy;
        known1[id]  = disp_rs1_rdy;
        known2[id]  = disp_rs2_rdy;
        val1_of[id] = mirror[disp_rs1_phy];
        val2_of[id] = mirror[disp_rs2_phy];
        // wakeup arriving with the dispatch itself
        for (int k = 0; k < cdb_width; k++) begin
            if (cdb_valid[k] && !disp_rs1_rdy && cdb_phy[k] == disp_rs1_phy) begin
                val1_of[id] = cdb_value[k];
                known1[id]  = 1'b1;
            end
            if (cdb_valid[k] && !disp_rs2_rdy && cdb_phy[k] == disp_rs2_phy) begin
                val2_of[id] = cdb_value[k];
                known2[id]  = 1'b1;
            end
        end
    endtask

    task automatic check_result();
        logic [rob_bits-1:0] id;
        logic                store;
        int                  nbytes;
        logic [xlen-1:0]     addr;
        logic [3:0]          mask;
        logic [xlen-1:0]     data;
        logic                mis;
        id = lsq_rob_id;
        if (!pend[id]) begin
            $display("Fail time=%0t rob id %0d reached the LSQ with nothing in flight", $time, id);
            err_count++;
            return;
        end
        store = (op_of[id] == op_sb) || (op_of[id] == op_sh) || (op_of[id] == op_sw);
        if (!known1[id] || (store && !known2[id])) begin
            $display("Fail time=%0t rob id %0d issued before its sources were broadcast",
                     $time, id);
            err_count++;
        end
        if (op_of[id] == op_lb || op_of[id] == op_lbu || op_of[id] == op_sb) begin
            nbytes = 1;
        end else if (op_of[id] == op_lh || op_of[id] == op_lhu || op_of[id] == op_sh) begin
            nbytes = 2;
        end else begin
            nbytes = 4;
        end
        addr = val1_of[id] + imm_of[id];
        // bytes past the end of the word are dropped
        mask = 4'(((1 << nbytes) - 1) << addr[1:0]);
        data = '0;
        if (store) begin
            for (int b = 0; b < 4; b++) begin
                data[8*b +: 8] = val2_of[id][8*(b % nbytes) +: 8];
            end
        end
        mis = (int'(addr[1:0]) % nbytes) != 0;
        compare("lsq_store", {31'd0, lsq_store}, {31'd0, store});
        compare("lsq_addr", lsq_addr, addr);
        compare("lsq_mask", {28'd0, lsq_mask}, {28'd0, mask});
        compare("lsq_data", lsq_data, data);
        compare("lsq_misaligned", {31'd0, lsq_misaligned}, {31'd0, mis});
        pend[id] = 1'b0;
        checked++;
    endtask

    // inputs and outputs are stable mid cycle
    always @(negedge clk) begin
        if (rst) begin
            pend = '0;
            for (int p = 0; p < 64; p++) begin
                mirror[p] = '0;
            end
        end else begin
            capture_wakeups();
            if (disp_valid && disp_ready) begin
                record_dispatch();
            end
            for (int k = 0; k < cdb_width; k++) begin
                if (cdb_valid[k]) begin
                    mirror[cdb_phy[k]] = cdb_value[k];
                end
            end
            if (lsq_valid) begin
                check_result();
            end
        end
        outstanding = $countones(pend);
    end

endmodule

`default_nettype wire

//--- test/mem_issue_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_issue_tb import mem_pkg::*;;

    localparam int half_period = 20;
    localparam int mode_load   = 0;
    localparam int mode_wait   = 1;
    localparam int mode_fill   = 2;
    localparam int mode_store  = 3;
    localparam int mode_mix    = 4;

    logic                clk = 1'b0;
    logic                rst;
    logic                disp_valid;
    logic                disp_ready;
    logic [rob_bits-1:0] disp_rob_id;
    logic [op_bits-1:0]  disp_op;
    logic [xlen-1:0]     disp_imm;
    logic [phy_bits-1:0] disp_rs1_phy;
    logic                disp_rs1_rdy;
    logic [phy_bits-1:0] disp_rs2_phy;
    logic                disp_rs2_rdy;
    logic                cdb_valid [cdb_width];
    logic [phy_bits-1:0] cdb_phy   [cdb_width];
    logic [xlen-1:0]     cdb_value [cdb_width];
    logic                lsq_valid;
    logic [rob_bits-1:0] lsq_rob_id;
    logic                lsq_store;
    logic [xlen-1:0]     lsq_addr;
    logic [3:0]          lsq_mask;
    logic [xlen-1:0]     lsq_data;
    logic                lsq_misaligned;

    int seed = 8;
    int cyc = 0;
    int sent = 0;
    int tb_errors = 0;
    int next_fresh = 1;
    int due [64];
    int lat;
    int total;
    logic [63:0] sched = '0;
    logic [63:0] bcast_done = 64'd1;
    logic [rob_bits-1:0] rob_next = '0;
    logic busy = 1'b0;
    logic rdy_seen = 1'b0;
    logic lsq_seen = 1'b0;
    logic just_acc = 1'b0;

    always #half_period clk = ~clk;

    mem_issue_top i_dut (.*);
    mem_issue_checker u_chk (.*);

    bind mem_issue_top mem_issue_props u_props (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .iss_valid  (iss_valid),
        .lsq_valid  (lsq_valid)
    );

    //////////////////////////////
    // cycle and producer tasks
    //////////////////////////////

    // sample mid cycle, then step to the next rising edge
    task automatic advance();
        @(negedge clk);
        rdy_seen = disp_ready;
        lsq_seen = lsq_valid;
        just_acc = busy && disp_ready;
        @(posedge clk);
        cyc++;
        if (just_acc) begin
            busy = 1'b0;
            disp_valid <= 1'b0;
            sent++;
        end
    endtask

    task automatic drive_cdb();
        int lane;
        logic [31:0] v;
        lane = 0;
        for (int p = 1; p < 64; p++) begin
            if (lane < cdb_width && sched[p] && due[p] <= cyc) begin
                v = $random(seed);
                if (v == 0) begin
                    v = 1;
                end
                cdb_valid[lane] <= 1'b1;
                cdb_phy[lane]   <= phy_bits'(p);
                cdb_value[lane] <= v;
                sched[p]      = 1'b0;
                bcast_done[p] = 1'b1;
                lane++;
            end
        end
        for (int k = lane; k < cdb_width; k++) begin
            cdb_valid[k] <= 1'b0;
        end
    endtask

    // fresh values for p1..p31, p32..p63 kept for later wakeups
    task automatic prime();
        int guard;
        for (int p = 1; p < 64; p++) begin
            sched[p]      = (p < 32);
            due[p]        = cyc;
            bcast_done[p] = 1'b0;
        end
        next_fresh = 32;
        guard = 0;
        while (sched != '0 && guard < 100) begin
            advance();
            drive_cdb();
            guard++;
        end
        if (sched != '0) begin
            $display("initial register broadcasts did not finish in time");
            tb_errors++;
        end
    endtask

    task automatic pick_src(input logic want, input logic hold,
                            output logic [phy_bits-1:0] p, output logic rdy);
        logic [31:0] r;
        r = $random(seed);
        if (want && next_fresh < 64) begin
            p = phy_bits'(next_fresh);
            next_fresh++;
            sched[p] = 1'b1;
            due[p]   = hold ? cyc + 100000 : cyc + int'(r % 7);
            rdy      = 1'b0;
        end else begin
            p = phy_bits'(r % 32);
            if (!bcast_done[p]) begin
                p = '0;
            end
            rdy = 1'b1;
        end
    endtask

    task automatic drive_op(input int mode);
        logic [31:0] r;
        logic [31:0] r2;
        logic [op_bits-1:0] op;
        logic store;
        logic [phy_bits-1:0] p1;
        logic [phy_bits-1:0] p2;
        logic k1;
        logic k2;
        r  = $random(seed);
        r2 = $random(seed);
        if (mode == mode_load) begin
            case (r % 5)
                0: op = op_lb;
                1: op = op_lh;
                2: op = op_lw;
                3: op = op_lbu;
                default: op = op_lhu;
            endcase
        end else if (mode == mode_store) begin
            case (r % 3)
                0: op = op_sb;
                1: op = op_sh;
                default: op = op_sw;
            endcase
        end else begin
            op = r[2:0];
        end
        store = (op == op_sb) || (op == op_sh) || (op == op_sw);
        pick_src((mode == mode_wait) || (mode == mode_fill) || (mode == mode_mix && r[8]),
                 mode == mode_fill, p1, k1);
        if (store) begin
            pick_src((mode == mode_wait) || (mode == mode_mix && r[9]), 1'b0, p2, k2);
        end else begin
            p2 = '0;
            k2 = 1'b1;
        end
        disp_valid   <= 1'b1;
        disp_rob_id  <= rob_next;
        disp_op      <= op;
        disp_imm     <= {{20{r2[11]}}, r2[11:0]};
        disp_rs1_phy <= p1;
        disp_rs1_rdy <= k1;
        disp_rs2_phy <= p2;
        disp_rs2_rdy <= k2;
        rob_next = rob_next + 5'd1;
        busy = 1'b1;
    endtask

    // dispatch only into a station that cannot fill before acceptance
    task automatic run_ops(input int n, input int mode);
        int start;
        int guard;
        logic [31:0] r;
        start = sent;
        guard = 0;
        while (sent - start < n && guard < n * 30 + 100) begin
            advance();
            r = $random(seed);
            if (!busy && rdy_seen && !just_acc && (mode != mode_mix || r[1:0] != 2'b00)) begin
                drive_op(mode);
            end
            drive_cdb();
            guard++;
        end
        if (sent - start < n) begin
            $display("dispatch stalled after %0d of %0d micro-ops", sent - start, n);
            tb_errors++;
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while ((u_chk.outstanding != 0 || sched != '0) && guard < 600) begin
            advance();
            drive_cdb();
            guard++;
        end
        if (u_chk.outstanding != 0) begin
            $display("drain timed out with %0d micro-ops in flight", u_chk.outstanding);
            tb_errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s done, errors so far %0d", num, name,
                 tb_errors + u_chk.err_count);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        rst          = 1'b1;
        disp_valid   = 1'b0;
        disp_rob_id  = '0;
        disp_op      = '0;
        disp_imm     = '0;
        disp_rs1_phy = '0;
        disp_rs1_rdy = 1'b0;
        disp_rs2_phy = '0;
        disp_rs2_rdy = 1'b0;
        for (int k = 0; k < cdb_width; k++) begin
            cdb_valid[k] = 1'b0;
            cdb_phy[k]   = '0;
            cdb_value[k] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 5; i++) begin
            advance();
            drive_cdb();
            if (!rdy_seen || lsq_seen) begin
                $display("idle station after reset: disp_ready=%b lsq_valid=%b",
                         rdy_seen, lsq_seen);
                tb_errors++;
            end
        end
        end_test(1, "reset state");

        prime();
        run_ops(1, mode_load);
        lat = 0;
        while (!lsq_seen && lat < 10) begin
            advance();
            drive_cdb();
            lat++;
        end
        // issue next cycle, then two registers
        if (lat != 3) begin
            $display("ready load reached the LSQ after %0d cycles instead of 3", lat);
            tb_errors++;
        end
        drain();
        end_test(2, "ready load latency");

        prime();
        run_ops(40, mode_wait);
        drain();
        end_test(3, "cdb wakeup and bypass");

        prime();
        run_ops(8, mode_fill);
        advance();
        drive_cdb();
        if (rdy_seen) begin
            $display("station accepts dispatch with 8 blocked entries");
            tb_errors++;
        end
        for (int p = 1; p < 64; p++) begin
            due[p] = cyc;
        end
        drain();
        advance();
        drive_cdb();
        if (!rdy_seen) begin
            $display("disp_ready stays low after the station drained");
            tb_errors++;
        end
        end_test(4, "full station");

        prime();
        run_ops(40, mode_store);
        drain();
        end_test(5, "store sizes");

        for (int c = 0; c < 6; c++) begin
            prime();
            run_ops(50, mode_mix);
            drain();
        end
        end_test(6, "random mix");

        if (u_chk.checked != sent) begin
            $display("%0d micro-ops dispatched but %0d reached the LSQ", sent, u_chk.checked);
            tb_errors++;
        end
        total = tb_errors + u_chk.err_count;
        $display("tests 6, micro-ops checked %0d, errors %0d", u_chk.checked, total);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/mem_pkg.sv
source/phys_regfile.sv
source/mem_rs.sv
source/mem_agu.sv
source/mem_issue_top.sv
test/mem_issue_props.sv
test/mem_issue_checker.sv
test/mem_issue_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = mem_issue_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
